//--- hdl/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// processor word address, split as tag | index | offset
`define CACHE_ADDR_W    25
`define CACHE_INDEX_W   2
`define CACHE_OFFSET_W  2
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`define CACHE_WORD_W    32
`define CACHE_WAYS      4

// field 0 is least recent, so way 0 goes first
`define CACHE_LRU_INIT  8'b11_10_01_00

`endif

//--- hdl/cache_pkg.sv
`default_nettype none
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef word_t [3:0] line_t;                  // word 0 in low bits
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] line_addr_t;   // {tag, index}

    typedef struct packed {
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef logic [`CACHE_WAYS-1:0] way_sel_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_num_t;
    typedef way_num_t [`CACHE_WAYS-1:0] lru_t;   // [0] oldest, top newest

    typedef enum logic [2:0] {
        IDLE,
        COMP,
        HIT,
        FETCH_REQ,
        FETCH_WAIT,
        FILL_STORE,
        WB_REQ,
        WB_WAIT
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/cache_way_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_way_if;

    cache_pkg::index_t index;
    cache_pkg::tag_t   tag;
    cache_pkg::line_t  wline;
    logic [3:0]        byte_en;
    logic [3:0]        word_en;
    logic              write;
    logic              fill;      // line fill, stored clean

    logic              hit;
    logic              valid;
    logic              dirty;
    cache_pkg::line_t  rline;
    cache_pkg::tag_t   rtag;      // for write-back address

    modport ctrl (
        output index, tag, wline, byte_en, word_en, write, fill,
        input  hit, valid, dirty, rline, rtag
    );

    modport way (
        input  index, tag, wline, byte_en, word_en, write, fill,
        output hit, valid, dirty, rline, rtag
    );

endinterface

`default_nettype wire

//--- hdl/cache_sram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_sram #(
    parameter type t_data = logic,
    parameter int  depth  = 4
) (
    input  wire                    clk,
    input  wire                    i_we,
    input  wire cache_pkg::index_t i_waddr,
    input  wire t_data             i_wdata,
    input  wire cache_pkg::index_t i_raddr,
    output t_data                  o_rdata
);

    t_data mem [depth];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // new data on same-address collision
        o_rdata <= (i_we && i_waddr == i_raddr) ? i_wdata : mem[i_raddr];
    end

endmodule

`default_nettype wire

//--- hdl/cache_way.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_way (
    input  wire       clk,
    input  wire       rst,
    cache_way_if.way  bus
);

    localparam int SETS = 2 ** `CACHE_INDEX_W;

    cache_pkg::line_t      rd_line;
    cache_pkg::line_t      wr_line;
    cache_pkg::tag_entry_t rd_entry;
    cache_pkg::tag_entry_t wr_entry;
    logic [SETS-1:0]       valid_bits;
    logic                  valid_q;

    // merge selected bytes into the stored line
    always_comb begin
        wr_line = rd_line;
        for (int w = 0; w < 4; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.fill || (bus.word_en[w] && bus.byte_en[b])) begin
                    wr_line[w][8*b +: 8] = bus.wline[w][8*b +: 8];
                end
            end
        end
    end

    assign wr_entry.dirty = !bus.fill;   // stores dirty the line
    assign wr_entry.tag   = bus.tag;

    cache_sram #(.t_data(cache_pkg::line_t), .depth(SETS)) data_ram (
        .clk     (clk),
        .i_we    (bus.write),
        .i_waddr (bus.index),
        .i_wdata (wr_line),
        .i_raddr (bus.index),
        .o_rdata (rd_line)
    );

    cache_sram #(.t_data(cache_pkg::tag_entry_t), .depth(SETS)) tag_ram (
        .clk     (clk),
        .i_we    (bus.write),
        .i_waddr (bus.index),
        .i_wdata (wr_entry),
        .i_raddr (bus.index),
        .o_rdata (rd_entry)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (bus.write) begin
                valid_bits[bus.index] <= 1'b1;
            end
            valid_q <= valid_bits[bus.index] || bus.write;   // same index as the rams
        end
    end

    assign bus.valid = valid_q;
    assign bus.hit   = valid_q && (rd_entry.tag == bus.tag);
    assign bus.dirty = valid_q && rd_entry.dirty;
    assign bus.rline = rd_line;
    assign bus.rtag  = rd_entry.tag;

endmodule

`default_nettype wire

//--- hdl/lru_order.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module lru_order (
    input  wire                      clk,
    input  wire                      rst,
    input  wire cache_pkg::index_t   i_index,
    input  wire                      i_touch,
    input  wire cache_pkg::way_num_t i_way,
    output cache_pkg::way_num_t      o_lru_way
);

    localparam int SETS = 2 ** `CACHE_INDEX_W;

    cache_pkg::lru_t     order [SETS];
    cache_pkg::lru_t     cur;
    cache_pkg::lru_t     nxt;
    cache_pkg::way_num_t pos;

    assign cur       = order[i_index];
    assign o_lru_way = cur[0];

    // touched way to the top, the ones above it slide down
    always_comb begin
        pos = '0;
        for (int k = 0; k < `CACHE_WAYS; k++) begin
            if (cur[k] == i_way) begin
                pos = cache_pkg::way_num_t'(k);
            end
        end
        nxt = cur;
        for (int k = 0; k < `CACHE_WAYS - 1; k++) begin
            if (k >= pos) begin
                nxt[k] = cur[k + 1];
            end
        end
        nxt[`CACHE_WAYS-1] = i_way;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                order[s] <= `CACHE_LRU_INIT;
            end
        end else if (i_touch) begin
            order[i_index] <= nxt;
        end
    end

    function automatic logic is_perm(cache_pkg::lru_t o);
        cache_pkg::way_sel_t seen;
        seen = '0;
        for (int k = 0; k < `CACHE_WAYS; k++) begin
            seen[o[k]] = 1'b1;
        end
        return &seen;
    endfunction

    // order stays a permutation across every update
    a_perm: assert property (@(posedge clk) disable iff (rst) is_perm(cur) && is_perm(nxt));

endmodule

`default_nettype wire

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`CACHE_ADDR_W-1:0]  i_p_addr,
    input  wire [3:0]                i_p_byte_en,
    input  wire cache_pkg::word_t    i_p_writedata,
    input  wire                      i_p_read,
    input  wire                      i_p_write,
    output cache_pkg::word_t         o_p_readdata,
    output logic                     o_p_readdata_valid,
    output logic                     o_p_waitrequest,
    output cache_pkg::line_addr_t    o_m_addr,
    output cache_pkg::line_t         o_m_writedata,
    output logic                     o_m_read,
    output logic                     o_m_write,
    input  wire cache_pkg::line_t    i_m_readdata,
    input  wire                      i_m_readdata_valid,
    input  wire                      i_m_waitrequest,
    output cache_pkg::index_t        o_lru_index,
    output logic                     o_lru_touch,
    output cache_pkg::way_num_t      o_lru_way,
    input  wire cache_pkg::way_num_t i_lru_way,
    cache_way_if.ctrl                ways [`CACHE_WAYS]
);

    cache_pkg::ctrl_state_t      state;
    logic [`CACHE_ADDR_W-1:0]    req_addr;
    logic [3:0]                  req_be;
    cache_pkg::word_t            req_data;
    logic                        req_write;
    cache_pkg::way_num_t         way_q;      // hit way or victim
    cache_pkg::way_num_t         hit_num;
    cache_pkg::way_num_t         victim;
    cache_pkg::way_sel_t         hit_vec;
    cache_pkg::way_sel_t         valid_vec;
    cache_pkg::way_sel_t         dirty_vec;
    cache_pkg::line_t            rline_vec [`CACHE_WAYS];
    cache_pkg::tag_t             rtag_vec [`CACHE_WAYS];
    cache_pkg::tag_t             req_tag;
    cache_pkg::index_t           req_index;
    cache_pkg::index_t           cur_index;
    logic [`CACHE_OFFSET_W-1:0]  req_offset;
    logic                        fill_now;
    logic                        store_now;

    assign req_tag    = req_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index  = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign req_offset = req_addr[`CACHE_OFFSET_W-1:0];
    // rams look up the incoming address on the acceptance edge
    assign cur_index  = (state == cache_pkg::IDLE) ?
                        i_p_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : req_index;

    assign fill_now  = (state == cache_pkg::FETCH_WAIT) && i_m_readdata_valid;
    assign store_now = (state == cache_pkg::HIT) || (state == cache_pkg::FILL_STORE);

    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
        assign ways[g].index   = cur_index;
        assign ways[g].tag     = req_tag;
        assign ways[g].wline   = (state == cache_pkg::FETCH_WAIT) ? i_m_readdata : {4{req_data}};
        assign ways[g].byte_en = req_be;
        assign ways[g].word_en = 4'b0001 << req_offset;
        assign ways[g].fill    = (state == cache_pkg::FETCH_WAIT);
        assign ways[g].write   = (fill_now || store_now) && (way_q == cache_pkg::way_num_t'(g));
        assign hit_vec[g]      = ways[g].hit;
        assign valid_vec[g]    = ways[g].valid;
        assign dirty_vec[g]    = ways[g].dirty;
        assign rline_vec[g]    = ways[g].rline;
        assign rtag_vec[g]     = ways[g].rtag;
    end

    // hit way, and first invalid way else lru
    always_comb begin
        hit_num = '0;
        victim  = i_lru_way;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_num = cache_pkg::way_num_t'(w);
            end
            if (!valid_vec[w]) begin
                victim = cache_pkg::way_num_t'(w);
            end
        end
    end

    assign o_lru_index = req_index;
    assign o_lru_touch = ((state == cache_pkg::COMP) && (|hit_vec)) || fill_now;
    assign o_lru_way   = (state == cache_pkg::COMP) ? hit_num : way_q;

    assign o_p_waitrequest = (state != cache_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= cache_pkg::IDLE;
            req_addr           <= '0;
            way_q              <= '0;
            o_p_readdata_valid <= 1'b0;
            o_m_read           <= 1'b0;
            o_m_write          <= 1'b0;
        end else begin
            o_p_readdata_valid <= 1'b0;
            case (state)
                cache_pkg::IDLE: begin
                    if (i_p_read || i_p_write) begin
                        req_addr  <= i_p_addr;
                        req_be    <= i_p_byte_en;
                        req_data  <= i_p_writedata;
                        req_write <= i_p_write;
                        state     <= cache_pkg::COMP;
                    end
                end
                cache_pkg::COMP: begin
                    if (|hit_vec) begin
                        way_q <= hit_num;
                        if (req_write) begin
                            state <= cache_pkg::HIT;
                        end else begin
                            o_p_readdata       <= rline_vec[hit_num][req_offset];
                            o_p_readdata_valid <= 1'b1;
                            state              <= cache_pkg::IDLE;
                        end
                    end else begin
                        way_q <= victim;
                        state <= dirty_vec[victim] ? cache_pkg::WB_REQ : cache_pkg::FETCH_REQ;
                    end
                end
                cache_pkg::HIT,
                cache_pkg::FILL_STORE: begin
                    state <= cache_pkg::IDLE;   // store done this cycle
                end
                cache_pkg::WB_REQ: begin
                    o_m_addr      <= {rtag_vec[way_q], req_index};
                    o_m_writedata <= rline_vec[way_q];
                    o_m_write     <= 1'b1;
                    state         <= cache_pkg::WB_WAIT;
                end
                cache_pkg::WB_WAIT: begin
                    if (!i_m_waitrequest) begin
                        o_m_write <= 1'b0;
                        state     <= cache_pkg::FETCH_REQ;
                    end
                end
                cache_pkg::FETCH_REQ: begin
                    o_m_addr <= {req_tag, req_index};
                    o_m_read <= 1'b1;
                    state    <= cache_pkg::FETCH_WAIT;
                end
                cache_pkg::FETCH_WAIT: begin
                    if (o_m_read && !i_m_waitrequest) begin
                        o_m_read <= 1'b0;
                    end
                    if (i_m_readdata_valid) begin
                        if (req_write) begin
                            state <= cache_pkg::FILL_STORE;
                        end else begin
                            o_p_readdata       <= i_m_readdata[req_offset];
                            o_p_readdata_valid <= 1'b1;
                            state              <= cache_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    a_mem_cmd_excl: assert property (@(posedge clk) disable iff (rst) !(o_m_read && o_m_write));

    // tags of the four ways never match twice
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        (state == cache_pkg::COMP) |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- hdl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`CACHE_ADDR_W-1:0] i_p_addr,
    input  wire [3:0]               i_p_byte_en,
    input  wire cache_pkg::word_t   i_p_writedata,
    input  wire                     i_p_read,
    input  wire                     i_p_write,
    output cache_pkg::word_t        o_p_readdata,
    output logic                    o_p_readdata_valid,
    output logic                    o_p_waitrequest,
    output cache_pkg::line_addr_t   o_m_addr,
    output cache_pkg::line_t        o_m_writedata,
    output logic                    o_m_read,
    output logic                    o_m_write,
    input  wire cache_pkg::line_t   i_m_readdata,
    input  wire                     i_m_readdata_valid,
    input  wire                     i_m_waitrequest
);

    cache_pkg::index_t   lru_index;
    logic                lru_touch;
    cache_pkg::way_num_t lru_way;
    cache_pkg::way_num_t lru_victim;

    cache_way_if way_bus [`CACHE_WAYS] ();

    cache_ctrl ctrl0 (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (i_p_addr),
        .i_p_byte_en        (i_p_byte_en),
        .i_p_writedata      (i_p_writedata),
        .i_p_read           (i_p_read),
        .i_p_write          (i_p_write),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_m_addr           (o_m_addr),
        .o_m_writedata      (o_m_writedata),
        .o_m_read           (o_m_read),
        .o_m_write          (o_m_write),
        .i_m_readdata       (i_m_readdata),
        .i_m_readdata_valid (i_m_readdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .o_lru_index        (lru_index),
        .o_lru_touch        (lru_touch),
        .o_lru_way          (lru_way),
        .i_lru_way          (lru_victim),
        .ways               (way_bus)
    );

    lru_order lru0 (
        .clk       (clk),
        .rst       (rst),
        .i_index   (lru_index),
        .i_touch   (lru_touch),
        .i_way     (lru_way),
        .o_lru_way (lru_victim)
    );

    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
        cache_way way0 (
            .clk (clk),
            .rst (rst),
            .bus (way_bus[g])
        );
    end

endmodule

`default_nettype wire

//--- testbench/cache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mem_model (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_read,
    input  wire                        i_write,
    input  wire cache_pkg::line_addr_t i_addr,
    input  wire cache_pkg::line_t      i_writedata,
    output cache_pkg::line_t           o_readdata,
    output logic                       o_readdata_valid,
    output logic                       o_waitrequest,
    output int                         o_wr_count,
    output cache_pkg::line_addr_t      o_wr_addr
);

    cache_pkg::line_t      store [cache_pkg::line_addr_t];   // written-back lines only
    cache_pkg::line_addr_t rd_addr;
    logic                  rd_pending;
    int unsigned           stall_left;
    int unsigned           delay_left;

    // backing word is its own word address xor a marker
    function automatic cache_pkg::line_t line_at(cache_pkg::line_addr_t a);
        cache_pkg::line_t l;
        if (store.exists(a)) begin
            return store[a];
        end
        for (int k = 0; k < 4; k++) begin
            l[k] = {7'b0, a, 2'(k)} ^ 32'h5A5A0000;
        end
        return l;
    endfunction

    assign o_waitrequest = (stall_left != 0);

    initial begin
        void'($urandom(67827));
        o_readdata       = '0;
        o_readdata_valid = 1'b0;
        o_wr_count       = 0;
        o_wr_addr        = '0;
        rd_addr          = '0;
        rd_pending       = 1'b0;
        stall_left       = 0;
        delay_left       = 0;
        forever begin
            @(posedge clk);
            o_readdata_valid <= 1'b0;
            if (rst) begin
                rd_pending <= 1'b0;
                stall_left <= 0;
            end else begin
                if (rd_pending) begin
                    if (delay_left == 0) begin
                        o_readdata       <= line_at(rd_addr);
                        o_readdata_valid <= 1'b1;
                        rd_pending       <= 1'b0;
                    end else begin
                        delay_left <= delay_left - 1;
                    end
                end
                if ((i_read || i_write) && stall_left == 0) begin   // accepted here
                    stall_left <= $urandom % 4;                    // for the next command
                    if (i_read) begin
                        rd_addr    <= i_addr;
                        rd_pending <= 1'b1;
                        delay_left <= $urandom % 4;
                    end else begin
                        store[i_addr] = i_writedata;
                        o_wr_count <= o_wr_count + 1;
                        o_wr_addr  <= i_addr;
                    end
                end else if (i_read || i_write) begin
                    stall_left <= stall_left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_tb;

    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_OPS      = 64;
    localparam int          FIELDS       = 6;
    localparam logic [31:0] NO_WB        = 32'hFFFF_FFFF;
    localparam logic [31:0] OP_READ      = 32'd1;
    localparam logic [31:0] OP_READ_HIT  = 32'd3;   // also checks hit timing
    localparam logic [31:0] OP_WRITE_HIT = 32'd4;

    logic                     clk;
    logic                     rst;
    logic [`CACHE_ADDR_W-1:0] p_addr;
    logic [3:0]               p_byte_en;
    cache_pkg::word_t         p_writedata;
    logic                     p_read;
    logic                     p_write;
    cache_pkg::word_t         p_readdata;
    logic                     p_readdata_valid;
    logic                     p_waitrequest;
    cache_pkg::line_addr_t    m_addr;
    cache_pkg::line_t         m_writedata;
    logic                     m_read;
    logic                     m_write;
    cache_pkg::line_t         m_readdata;
    logic                     m_readdata_valid;
    logic                     m_waitrequest;
    int                       wr_count;
    cache_pkg::line_addr_t    wr_addr;

    logic [31:0] tdata [MAX_OPS*FIELDS];
    int          n_ops;
    int          cycle_cnt = 0;
    int          cycle_limit;

    cache_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (p_addr),
        .i_p_byte_en        (p_byte_en),
        .i_p_writedata      (p_writedata),
        .i_p_read           (p_read),
        .i_p_write          (p_write),
        .o_p_readdata       (p_readdata),
        .o_p_readdata_valid (p_readdata_valid),
        .o_p_waitrequest    (p_waitrequest),
        .o_m_addr           (m_addr),
        .o_m_writedata      (m_writedata),
        .o_m_read           (m_read),
        .o_m_write          (m_write),
        .i_m_readdata       (m_readdata),
        .i_m_readdata_valid (m_readdata_valid),
        .i_m_waitrequest    (m_waitrequest)
    );

    cache_mem_model mem0 (
        .clk              (clk),
        .rst              (rst),
        .i_read           (m_read),
        .i_write          (m_write),
        .i_addr           (m_addr),
        .i_writedata      (m_writedata),
        .o_readdata       (m_readdata),
        .o_readdata_valid (m_readdata_valid),
        .o_waitrequest    (m_waitrequest),
        .o_wr_count       (wr_count),
        .o_wr_addr        (wr_addr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, a request never completed", cycle_cnt);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value check");
        end
    endtask

    task automatic run_op(input int n);
        logic [31:0] op;
        logic [31:0] exp_rdata;
        logic [31:0] exp_wb;
        logic        is_read;
        int          lat;
        int          wr_before;
        op        = tdata[n*FIELDS];
        exp_rdata = tdata[n*FIELDS+4];
        exp_wb    = tdata[n*FIELDS+5];
        is_read   = (op == OP_READ) || (op == OP_READ_HIT);
        wr_before = wr_count;
        lat       = 0;
        if (op > OP_WRITE_HIT) begin
            $display("Unknown operation code %0d in data line %0d", op, n);
            $display("Simulation failed");
            $fatal(1, "bad data file");
        end
        p_addr      <= tdata[n*FIELDS+1][`CACHE_ADDR_W-1:0];
        p_byte_en   <= tdata[n*FIELDS+2][3:0];
        p_writedata <= tdata[n*FIELDS+3];
        p_read      <= is_read;
        p_write     <= !is_read;
        @(posedge clk);
        while (p_waitrequest) begin   // request held until accepted
            @(posedge clk);
        end
        p_read  <= 1'b0;
        p_write <= 1'b0;
        if (is_read) begin
            do begin
                @(posedge clk);
                lat++;
            end while (!p_readdata_valid);
            check_val("o_p_readdata", p_readdata, exp_rdata);
            if (op == OP_READ_HIT) begin
                check_val("o_p_readdata_valid latency", lat, 2);
            end
            @(posedge clk);
            check_val("o_p_readdata_valid", p_readdata_valid, 0);   // single pulse
        end else begin
            @(posedge clk);
            while (p_waitrequest) begin
                lat++;
                @(posedge clk);
            end
            if (op == OP_WRITE_HIT) begin
                check_val("o_p_waitrequest cycles", lat, 2);
            end
        end
        if (exp_wb == NO_WB) begin
            check_val("o_m_write count", wr_count - wr_before, 0);
        end else begin
            check_val("o_m_write count", wr_count - wr_before, 1);
            check_val("o_m_addr", 32'(wr_addr), exp_wb);
        end
    endtask

    initial begin
        rst         = 1'b1;
        p_addr      = '0;
        p_byte_en   = '0;
        p_writedata = '0;
        p_read      = 1'b0;
        p_write     = 1'b0;
        for (int i = 0; i < MAX_OPS*FIELDS; i++) begin
            tdata[i] = '0;
        end
        $readmemh("testbench/cache_testdata.txt", tdata);
        n_ops = 0;
        while (n_ops < MAX_OPS && tdata[n_ops*FIELDS] != 0) begin
            n_ops++;
        end
        cycle_limit = n_ops * 200 + RESET_CYCLES;
        if (n_ops == 0) begin
            $display("No operations found in testbench/cache_testdata.txt");
            $display("Simulation failed");
            $fatal(1, "empty data file");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < n_ops; n++) begin
            run_op(n);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_way_if.sv
hdl/cache_sram.sv
hdl/cache_way.sv
hdl/lru_order.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
testbench/cache_mem_model.sv
testbench/cache_tb.sv

//--- testbench/cache_testdata.txt
// op addr byte_en wdata exp_rdata exp_wb_line_addr (hex, FFFFFFFF = no write-back)
// op 1 read, 2 write, 3 read with hit timing, 4 write with hit timing
1 00000121 0 00000000 5A5A0121 FFFFFFFF
4 00000121 3 DEADBEEF 00000000 FFFFFFFF
3 00000121 0 00000000 5A5ABEEF FFFFFFFF
3 00000122 0 00000000 5A5A0122 FFFFFFFF
2 00000233 C 11223344 00000000 FFFFFFFF
3 00000233 0 00000000 11220233 FFFFFFFF
// five lines into set 1, the fifth evicts way 0
2 00000404 F CAFE0404 00000000 FFFFFFFF
2 00000414 F CAFE0414 00000000 FFFFFFFF
2 00000424 5 12345678 00000000 FFFFFFFF
2 00000434 F CAFE0434 00000000 FFFFFFFF
2 00000444 F CAFE0444 00000000 00000101
// touch the oldest line, then evict by the promote rule
3 00000415 0 00000000 5A5A0415 FFFFFFFF
2 00000454 F CAFE0454 00000000 00000109
1 00000404 0 00000000 CAFE0404 0000010D
1 00000424 0 00000000 5A340478 00000111
3 00000405 0 00000000 5A5A0405 FFFFFFFF
3 00000121 0 00000000 5A5ABEEF FFFFFFFF
